//--- Makefile
# Verilator simulation of the split L1 cache

VERILATOR ?= verilator
TOP       ?= tb_cache_manage_unit
FILELIST  ?= cache_manage_unit.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= RESULT: PASS

.PHONY: sim clean

# Passes only when the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- cache_manage_unit.f
design/cache_pkg.sv
design/cache_2ways.sv
design/cache_control.sv
design/cache_manage_unit.sv
verif/tb_main_memory.sv
verif/cache_manage_unit_assert.sv
verif/tb_cache_manage_unit.sv

//--- design/cache_2ways.sv
`default_nettype none
`timescale 1ns/1ps

module cache_2ways #(
    parameter int OFFSET_WIDTH = 2,
    parameter int INDEX_WIDTH  = 4,
    parameter int ADDR_WIDTH   = 16,
    parameter int DATA_WIDTH   = 32,
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::cache_cmd_t   cmd,
    input  logic [TAG_WIDTH-1:0]    tag_in,
    input  logic [INDEX_WIDTH-1:0]  index,
    input  logic [OFFSET_WIDTH-1:0] word_sel,
    input  logic [DATA_WIDTH-1:0]   data_in,     // CPU store data
    input  logic [DATA_WIDTH-1:0]   fill_word,   // Word from memory
    output cache_pkg::cache_resp_t  resp,
    output logic [DATA_WIDTH-1:0]   data_out,
    output logic [TAG_WIDTH-1:0]    victim_tag,
    output logic [DATA_WIDTH-1:0]   victim_word
);

    import cache_pkg::*;

    localparam int SETS       = 1 << INDEX_WIDTH;
    localparam int BLOCK_SIZE = 1 << OFFSET_WIDTH;
    localparam int LANE_WIDTH = DATA_WIDTH / 4;  // One lane per byte enable

    // Storage, two ways deep
    logic [TAG_WIDTH-1:0]  tag_mem  [2][SETS];
    logic [DATA_WIDTH-1:0] data_mem [2][SETS][BLOCK_SIZE];

    logic [1:0][SETS-1:0]  valid_q;
    logic [1:0][SETS-1:0]  dirty_q;
    logic [SETS-1:0]       lru_q;     // Way to replace next in each set

    logic [1:0] way_hit;
    logic       any_hit;
    logic       hit_way;
    logic       victim_way;
    logic       do_access;
    logic       do_write;
    logic       do_fill;

    ////////////////////////////////////////////////////////////////////////////
    // Tag compare and victim choice
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag_in);
        end
    end

    assign any_hit = |way_hit;
    assign hit_way = way_hit[1];

    // Empty way first, LRU way otherwise
    always_comb begin
        if (!valid_q[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];
        end
    end

    assign do_access = ((cmd.op == OP_LOOKUP) || (cmd.op == OP_WRITE_WORD)) && any_hit;
    assign do_write  = (cmd.op == OP_WRITE_WORD) && any_hit;
    assign do_fill   = (cmd.op == OP_FILL_WORD);

    assign resp.hit   = any_hit;
    assign resp.dirty = dirty_q[victim_way][index];
    assign resp.valid = valid_q[victim_way][index];

    // Reads are combinational
    assign data_out    = any_hit ? data_mem[hit_way][index][word_sel] : '0;
    assign victim_tag  = tag_mem[victim_way][index];
    assign victim_word = data_mem[victim_way][index][word_sel];

    ////////////////////////////////////////////////////////////////////////////
    // Tag and data writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_fill) begin
            data_mem[victim_way][index][word_sel] <= fill_word;
            if (cmd.last_word) begin
                tag_mem[victim_way][index] <= tag_in;  // Line becomes usable
            end
        end else if (do_write) begin
            for (int b = 0; b < 4; b++) begin
                if (cmd.byte_en[b]) begin
                    data_mem[hit_way][index][word_sel][b*LANE_WIDTH +: LANE_WIDTH] <=
                        data_in[b*LANE_WIDTH +: LANE_WIDTH];
                end
            end
        end
    end

    // Line state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (do_fill && cmd.last_word) begin
            valid_q[victim_way][index] <= 1'b1;
            dirty_q[victim_way][index] <= 1'b0;
            lru_q[index]               <= ~victim_way;  // New line is most recent
        end else begin
            if (do_access) begin
                lru_q[index] <= ~hit_way;
            end
            if (do_write) begin
                dirty_q[hit_way][index] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cache_control.sv
`default_nettype none
`timescale 1ns/1ps

module cache_control #(
    parameter int OFFSET_WIDTH = 2
) (
    input  logic                     ic_read,
    input  logic                     dc_read,
    input  logic                     dc_write,
    input  logic [3:0]               dc_byte_en,
    input  cache_pkg::cache_resp_t   ic_resp,
    input  cache_pkg::cache_resp_t   dc_resp,
    input  cache_pkg::cache_status_e status,
    input  logic [OFFSET_WIDTH-1:0]  counter,
    input  logic [OFFSET_WIDTH-1:0]  ic_offset,
    input  logic [OFFSET_WIDTH-1:0]  dc_offset,
    input  logic                     mem_ready,
    output cache_pkg::cache_cmd_t    ic_cmd,
    output cache_pkg::cache_cmd_t    dc_cmd,
    output logic [OFFSET_WIDTH-1:0]  ic_word_sel,
    output logic [OFFSET_WIDTH-1:0]  dc_word_sel,
    output cache_pkg::cache_status_e status_next,
    output logic [OFFSET_WIDTH-1:0]  counter_next,
    output logic                     mem_en,
    output logic                     mem_write,
    output logic [1:0]               addr_sel      // 00 ic fill, 01 dc fill, 1x write-back
);

    import cache_pkg::*;

    localparam cache_cmd_t CMD_IDLE = '{
        op:        OP_IDLE,
        byte_en:   4'b0000,
        last_word: 1'b0,
        spare:     2'b00
    };

    logic ic_miss;
    logic dc_miss;
    logic victim_dirty;
    logic last_word;

    assign ic_miss      = ic_read && !ic_resp.hit;
    assign dc_miss      = (dc_read || dc_write) && !dc_resp.hit;
    assign victim_dirty = dc_resp.valid && dc_resp.dirty;
    assign last_word    = &counter;  // Final word of the block

    always_comb begin
        ic_cmd       = CMD_IDLE;
        dc_cmd       = CMD_IDLE;
        ic_word_sel  = ic_offset;
        dc_word_sel  = dc_offset;
        status_next  = status;
        counter_next = counter;
        mem_en       = 1'b0;
        mem_write    = 1'b0;
        addr_sel     = 2'b00;

        unique case (status)
            ////////////////////////////////////////////////////////////////////
            // Hit path and miss detection
            ////////////////////////////////////////////////////////////////////
            STAT_NORMAL: begin
                counter_next = '0;
                if (ic_read) begin
                    ic_cmd.op = OP_LOOKUP;
                end
                if (dc_write) begin
                    dc_cmd.op      = OP_WRITE_WORD;
                    dc_cmd.byte_en = dc_byte_en;
                end else if (dc_read) begin
                    dc_cmd.op = OP_LOOKUP;
                end

                // Dirty victim goes out before anything comes in
                if (dc_miss && victim_dirty) begin
                    status_next = STAT_DC_WRITEBACK;
                end else if (dc_miss && ic_miss) begin
                    status_next = STAT_DOUBLE_MISS;
                end else if (dc_miss) begin
                    status_next = STAT_DC_MISS;
                end else if (ic_miss) begin
                    status_next = STAT_IC_MISS;
                end else begin
                    status_next = STAT_NORMAL;
                end
            end

            STAT_DC_WRITEBACK: begin
                mem_en      = 1'b1;
                mem_write   = 1'b1;
                addr_sel    = 2'b10;
                dc_word_sel = counter;  // Victim word on mem_wdata
                if (mem_ready) begin
                    counter_next = counter + 1'b1;
                    if (last_word) begin
                        // Instruction side rechecked here
                        status_next = ic_miss ? STAT_DOUBLE_MISS : STAT_DC_MISS;
                    end
                end
            end

            STAT_DC_MISS, STAT_DOUBLE_MISS: begin
                mem_en      = 1'b1;
                addr_sel    = 2'b01;
                dc_word_sel = counter;
                if (mem_ready) begin
                    dc_cmd.op        = OP_FILL_WORD;
                    dc_cmd.last_word = last_word;
                    counter_next     = counter + 1'b1;
                    if (last_word) begin
                        status_next = (status == STAT_DOUBLE_MISS) ? STAT_IC_MISS
                                                                   : STAT_NORMAL;
                    end
                end
            end

            STAT_IC_MISS: begin
                mem_en      = 1'b1;
                ic_word_sel = counter;
                if (mem_ready) begin
                    ic_cmd.op        = OP_FILL_WORD;
                    ic_cmd.last_word = last_word;
                    counter_next     = counter + 1'b1;
                    if (last_word) begin
                        status_next = STAT_NORMAL;
                    end
                end
            end

            default: begin
                status_next = STAT_NORMAL;  // Unused encodings recover
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/cache_manage_unit.sv
`default_nettype none
`timescale 1ns/1ps

module cache_manage_unit #(
    parameter int OFFSET_WIDTH = 2,
    parameter int INDEX_WIDTH  = 4,
    parameter int ADDR_WIDTH   = 16,
    parameter int DATA_WIDTH   = 32,
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,
    // CPU side
    input  logic                  ic_read,
    input  logic [ADDR_WIDTH-1:0] ic_addr,
    input  logic                  dc_read,
    input  logic                  dc_write,
    input  logic [3:0]            dc_byte_en,
    input  logic [ADDR_WIDTH-1:0] dc_addr,
    input  logic [DATA_WIDTH-1:0] dc_wdata,
    output logic [DATA_WIDTH-1:0] ic_rdata,
    output logic [DATA_WIDTH-1:0] dc_rdata,
    output logic                  mem_stall,
    // Memory side
    input  logic                  mem_ready,
    input  logic [DATA_WIDTH-1:0] mem_rdata,
    output logic                  mem_en,
    output logic                  mem_write,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [DATA_WIDTH-1:0] mem_wdata
);

    import cache_pkg::*;

    cache_status_e            status;
    cache_status_e            status_next;
    logic [OFFSET_WIDTH-1:0]  counter;       // Word within the block in transfer
    logic [OFFSET_WIDTH-1:0]  counter_next;
    logic                     write_after_load;

    cache_cmd_t               ic_cmd, dc_cmd;
    cache_resp_t              ic_resp, dc_resp;
    logic [OFFSET_WIDTH-1:0]  ic_word_sel, dc_word_sel;
    logic [1:0]               addr_sel;
    logic [TAG_WIDTH-1:0]     dc_victim_tag;

    ////////////////////////////////////////////////////////////////////////////
    // Address split and memory address
    ////////////////////////////////////////////////////////////////////////////

    logic [TAG_WIDTH-1:0]    ic_tag, dc_tag;
    logic [INDEX_WIDTH-1:0]  ic_index, dc_index;
    logic [OFFSET_WIDTH-1:0] ic_offset, dc_offset;

    assign ic_tag    = ic_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign ic_index  = ic_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign ic_offset = ic_addr[OFFSET_WIDTH-1:0];
    assign dc_tag    = dc_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign dc_index  = dc_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign dc_offset = dc_addr[OFFSET_WIDTH-1:0];

    always_comb begin
        if (addr_sel[1]) begin
            mem_addr = {dc_victim_tag, dc_index, counter};  // Write-back target
        end else if (addr_sel[0]) begin
            mem_addr = {dc_tag, dc_index, counter};
        end else begin
            mem_addr = {ic_tag, ic_index, counter};
        end
    end

    cache_control #(
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) u_control (
        .ic_read      (ic_read),
        .dc_read      (dc_read),
        .dc_write     (dc_write),
        .dc_byte_en   (dc_byte_en),
        .ic_resp      (ic_resp),
        .dc_resp      (dc_resp),
        .status       (status),
        .counter      (counter),
        .ic_offset    (ic_offset),
        .dc_offset    (dc_offset),
        .mem_ready    (mem_ready),
        .ic_cmd       (ic_cmd),
        .dc_cmd       (dc_cmd),
        .ic_word_sel  (ic_word_sel),
        .dc_word_sel  (dc_word_sel),
        .status_next  (status_next),
        .counter_next (counter_next),
        .mem_en       (mem_en),
        .mem_write    (mem_write),
        .addr_sel     (addr_sel)
    );

    // Instruction side is read-only
    cache_2ways #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH)
    ) u_icache (
        .clk         (clk),
        .rst         (rst),
        .cmd         (ic_cmd),
        .tag_in      (ic_tag),
        .index       (ic_index),
        .word_sel    (ic_word_sel),
        .data_in     ('0),
        .fill_word   (mem_rdata),
        .resp        (ic_resp),
        .data_out    (ic_rdata),
        .victim_tag  (),
        .victim_word ()
    );

    cache_2ways #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH)
    ) u_dcache (
        .clk         (clk),
        .rst         (rst),
        .cmd         (dc_cmd),
        .tag_in      (dc_tag),
        .index       (dc_index),
        .word_sel    (dc_word_sel),
        .data_in     (dc_wdata),
        .fill_word   (mem_rdata),
        .resp        (dc_resp),
        .data_out    (dc_rdata),
        .victim_tag  (dc_victim_tag),
        .victim_word (mem_wdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // State registers and stall
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            status           <= STAT_NORMAL;
            counter          <= '0;
            write_after_load <= 1'b0;
        end else begin
            if (status == STAT_NORMAL) begin
                write_after_load <= 1'b0;
            end else if (dc_write) begin
                write_after_load <= 1'b1;  // Store completes after the fill
            end
            // Miss states move only on a memory word
            if ((status == STAT_NORMAL) || mem_ready) begin
                status  <= status_next;
                counter <= counter_next;
            end
        end
    end

    assign mem_stall = (status != STAT_NORMAL)      // Miss in progress
                    || (status_next != STAT_NORMAL) // Miss seen this cycle
                    || write_after_load;

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Manager state
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        STAT_NORMAL       = 3'd0,  // No miss in progress
        STAT_IC_MISS      = 3'd1,  // Filling an instruction line
        STAT_DC_MISS      = 3'd2,  // Filling a data line
        STAT_DC_WRITEBACK = 3'd3,  // Dirty data victim going out
        STAT_DOUBLE_MISS  = 3'd4   // Data fill first, instruction fill pending
    } cache_status_e;

    ////////////////////////////////////////////////////////////////////////////
    // Array commands and responses
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_IDLE       = 2'd0,
        OP_LOOKUP     = 2'd1,  // Tag compare, read on hit
        OP_WRITE_WORD = 2'd2,  // Byte write on hit, marks line dirty
        OP_FILL_WORD  = 2'd3   // One fill word into the victim way
    } cache_op_e;

    typedef struct packed {
        cache_op_e  op;
        logic [3:0] byte_en;
        logic       last_word;  // Fill ends with this word
        logic [1:0] spare;
    } cache_cmd_t;

    // Dirty and valid describe the victim way of the addressed set
    typedef struct packed {
        logic hit;
        logic dirty;
        logic valid;
    } cache_resp_t;

endpackage

`default_nettype wire

//--- verif/cache_manage_unit_assert.sv
`default_nettype none
`timescale 1ns/1ps

module cache_manage_unit_assert (
    input wire logic clk,
    input wire logic rst,
    input wire logic mem_en,
    input wire logic mem_write,
    input wire logic mem_stall
);

    // Memory port quiet right after reset
    idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!mem_en && !mem_write))
        else $error("memory port active right after reset");

    write_needs_enable: assert property (@(posedge clk) disable iff (rst)
        mem_write |-> mem_en)
        else $error("mem_write high without mem_en");

    // Any memory transfer stalls the CPU
    enable_needs_stall: assert property (@(posedge clk) disable iff (rst)
        mem_en |-> mem_stall)
        else $error("mem_en high without mem_stall");

    no_stall_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !mem_stall)
        else $error("mem_stall high in the first cycle after reset");

endmodule

bind cache_manage_unit cache_manage_unit_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .mem_en    (mem_en),
    .mem_write (mem_write),
    .mem_stall (mem_stall)
);

`default_nettype wire

//--- verif/tb_cache_manage_unit.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cache_manage_unit;

    localparam int OFFSET_WIDTH = 2;
    localparam int INDEX_WIDTH  = 4;
    localparam int ADDR_WIDTH   = 16;
    localparam int DATA_WIDTH   = 32;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int ACCESS_COUNT = 240;
    localparam int BLOCK_SIZE   = 1 << OFFSET_WIDTH;
    localparam int MAX_WAIT     = 6;  // Cycles per word, worst case
    // Write-back, data fill and instruction fill in a row
    localparam int WORST_MISS   = 3 * BLOCK_SIZE * MAX_WAIT + 4;
    localparam longint TIMEOUT_NS = longint'(ACCESS_COUNT) * WORST_MISS * CLK_PERIOD * 2
                                  + RESET_CYCLES * CLK_PERIOD;

    logic                  clk;
    logic                  rst;
    logic                  ic_read;
    logic [ADDR_WIDTH-1:0] ic_addr;
    logic                  dc_read;
    logic                  dc_write;
    logic [3:0]            dc_byte_en;
    logic [ADDR_WIDTH-1:0] dc_addr;
    logic [DATA_WIDTH-1:0] dc_wdata;
    logic [DATA_WIDTH-1:0] ic_rdata;
    logic [DATA_WIDTH-1:0] dc_rdata;
    logic                  mem_stall;
    logic                  mem_ready;
    logic [DATA_WIDTH-1:0] mem_rdata;
    logic                  mem_en;
    logic                  mem_write;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0] mem_wdata;

    logic [DATA_WIDTH-1:0] shadow [1 << ADDR_WIDTH];  // Expected word per address
    logic [31:0]           rand_state;
    logic                  stalled;
    int                    errors;
    int                    checks;
    int                    tests_run;
    int                    tests_failed;
    int                    errs_at_start;

    cache_manage_unit #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .ic_read    (ic_read),
        .ic_addr    (ic_addr),
        .dc_read    (dc_read),
        .dc_write   (dc_write),
        .dc_byte_en (dc_byte_en),
        .dc_addr    (dc_addr),
        .dc_wdata   (dc_wdata),
        .ic_rdata   (ic_rdata),
        .dc_rdata   (dc_rdata),
        .mem_stall  (mem_stall),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_en     (mem_en),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    tb_main_memory #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .SEED       (32'h6002c185)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_en    (mem_en),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Every address bit reaches the result
    function automatic logic [31:0] pattern_word(input logic [15:0] a);
        logic [31:0] x;
        x = {16'h0000, a} * 32'h9e3779b1;
        x = x ^ (x >> 15) ^ {a, ~a};
        return x;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // One CPU request, held until mem_stall drops
    task automatic access(input logic do_ic, input logic [15:0] ia,
                          input logic do_rd, input logic do_wr, input logic [3:0] be,
                          input logic [15:0] da, input logic [31:0] wd,
                          output logic saw_stall);
        @(negedge clk);
        ic_read    = do_ic;
        ic_addr    = ia;
        dc_read    = do_rd;
        dc_write   = do_wr;
        dc_byte_en = be;
        dc_addr    = da;
        dc_wdata   = wd;
        saw_stall  = 1'b0;
        #1;
        while (mem_stall) begin
            saw_stall = 1'b1;
            @(negedge clk);
            #1;
        end
        if (do_ic) check_word("ic_rdata", shadow[ia], ic_rdata);
        if (do_rd) check_word("dc_rdata", shadow[da], dc_rdata);
        if (do_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) shadow[da][b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        @(negedge clk);
        ic_read  = 1'b0;  // Back to idle
        dc_read  = 1'b0;
        dc_write = 1'b0;
    endtask

    task automatic expect_hit(input string what, input logic saw_stall);
        checks++;
        assert (!saw_stall) else begin
            $display("%s stalled although the block was already cached", what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        ic_read      = 1'b0;
        ic_addr      = '0;
        dc_read      = 1'b0;
        dc_write     = 1'b0;
        dc_byte_en   = 4'h0;
        dc_addr      = '0;
        dc_wdata     = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rand_state   = 32'h6002c185;
        for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
            shadow[a]   = pattern_word(16'(a));
            u_mem.mem[a] = pattern_word(16'(a));
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        errs_at_start = errors;  // Cold misses, then hits in the same blocks
        access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0, 16'h0010, 32'h0, stalled);
        access(1'b1, 16'h0400, 1'b0, 1'b0, 4'h0, 16'h0, 32'h0, stalled);
        access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0, 16'h0012, 32'h0, stalled);
        expect_hit("data read", stalled);
        access(1'b1, 16'h0403, 1'b0, 1'b0, 4'h0, 16'h0, 32'h0, stalled);
        expect_hit("instruction read", stalled);
        finish_test("cold_miss_then_hit", errs_at_start);

        errs_at_start = errors;  // First write misses
        access(1'b0, 16'h0, 1'b0, 1'b1, 4'b0011, 16'h0021, 32'h1122_3344, stalled);
        access(1'b0, 16'h0, 1'b0, 1'b1, 4'b1100, 16'h0021, 32'h5566_7788, stalled);
        access(1'b0, 16'h0, 1'b0, 1'b1, 4'b0100, 16'h0021, 32'h00ab_0000, stalled);
        access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0, 16'h0021, 32'h0, stalled);
        finish_test("byte_enable_writes", errs_at_start);

        errs_at_start = errors;  // Tags 0, 1, 2 at index 5
        access(1'b0, 16'h0, 1'b0, 1'b1, 4'hf, 16'h0015, 32'hdead_0015, stalled);
        access(1'b0, 16'h0, 1'b0, 1'b1, 4'hf, 16'h0055, 32'hdead_0055, stalled);
        access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0, 16'h0095, 32'h0, stalled);
        access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0, 16'h0015, 32'h0, stalled);
        access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0, 16'h0055, 32'h0, stalled);
        finish_test("dirty_eviction", errs_at_start);

        errs_at_start = errors;
        access(1'b1, 16'h04c0, 1'b1, 1'b0, 4'h0, 16'h00e0, 32'h0, stalled);
        access(1'b0, 16'h0, 1'b0, 1'b1, 4'hf, 16'h0016, 32'hbeef_0016, stalled);
        access(1'b0, 16'h0, 1'b0, 1'b1, 4'hf, 16'h0056, 32'hbeef_0056, stalled);
        // Dirty victim, so write-back comes ahead of both fills
        access(1'b1, 16'h04a4, 1'b1, 1'b0, 4'h0, 16'h0095, 32'h0, stalled);
        access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0, 16'h0016, 32'h0, stalled);
        access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0, 16'h0056, 32'h0, stalled);
        finish_test("double_miss", errs_at_start);

        errs_at_start = errors;
        for (int i = 0; i < 200; i++) begin
            rand_state = lcg_step(rand_state);
            case (rand_state[31:30])
                2'd0: access(1'b1, {8'h04, rand_state[23:16]}, 1'b0, 1'b0, 4'h0,
                             16'h0, 32'h0, stalled);
                2'd1: access(1'b0, 16'h0, 1'b1, 1'b0, 4'h0,
                             {8'h00, rand_state[15:8]}, 32'h0, stalled);
                2'd2: access(1'b0, 16'h0, 1'b0, 1'b1, rand_state[27:24] | 4'b0001,
                             {8'h00, rand_state[15:8]}, lcg_step(rand_state), stalled);
                default: access(1'b1, {8'h04, rand_state[23:16]}, 1'b1, 1'b0, 4'h0,
                                {8'h00, rand_state[15:8]}, 32'h0, stalled);
            endcase
        end
        finish_test("random_mix", errs_at_start);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_main_memory.sv
`default_nettype none
`timescale 1ns/1ps

module tb_main_memory #(
    parameter int          ADDR_WIDTH = 16,
    parameter int          DATA_WIDTH = 32,
    parameter logic [31:0] SEED       = 32'h6002c185
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_en,
    input  logic                  mem_write,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic [DATA_WIDTH-1:0] mem_wdata,
    output logic                  mem_ready,
    output logic [DATA_WIDTH-1:0] mem_rdata
);

    // Word storage, filled by the testbench before reset ends
    logic [DATA_WIDTH-1:0] mem [1 << ADDR_WIDTH];

    logic [31:0] lcg_state;
    logic [1:0]  wait_cnt;
    logic        busy;      // Word accepted, latency running

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // One ready pulse per word, 1 to 4 cycles after the request
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        mem_ready <= 1'b0;
        if (rst) begin
            busy      <= 1'b0;
            wait_cnt  <= 2'd0;
            lcg_state <= SEED;
            mem_rdata <= '0;
        end else if (mem_en && !mem_ready) begin
            if (!busy) begin
                busy      <= 1'b1;
                lcg_state <= lcg_step(lcg_state);
                wait_cnt  <= lcg_state[31:30];  // Upper bits are the better ones
            end else if (wait_cnt == 2'd0) begin
                busy      <= 1'b0;
                mem_ready <= 1'b1;
                if (mem_write) begin
                    mem[mem_addr] <= mem_wdata;
                end else begin
                    mem_rdata <= mem[mem_addr];
                end
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire
